// File: verilog/tinyrv1_pkg.sv
// Shared types for the TinyRV1 decode/issue stage
// seq_num fields are SEQ_MAX wide; users may carry fewer bits in the low end
// Two execute pipes only; routing depends on the TinyRV1 opcode set

package tinyrv1_pkg;

  // ----------------------------------------
  // Sizes and pipe indices
  // ----------------------------------------

  localparam int SEQ_MAX     = 8;
  localparam int NUM_PIPES   = 2;
  localparam int PIPE_ALU    = 0;
  localparam int PIPE_MULMEM = 1;

  // ----------------------------------------
  // Instruction field encodings
  // ----------------------------------------

  // Major opcodes in inst[6:0]
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // funct3 in inst[14:12]
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_MUL  = 3'b000;
  localparam logic [2:0] F3_ADDI = 3'b000;
  localparam logic [2:0] F3_LW   = 3'b010;
  localparam logic [2:0] F3_SW   = 3'b010;
  localparam logic [2:0] F3_JR   = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;

  // funct7 in inst[31:25]
  localparam logic [6:0] F7_ADD = 7'b0000000;
  localparam logic [6:0] F7_MUL = 7'b0000001;

  // ----------------------------------------
  // Decoded operation and immediate format
  // ----------------------------------------

  typedef enum logic [3:0] {
    op_add,
    op_addi,
    op_mul,
    op_lw,
    op_sw,
    op_jal,
    op_jr,
    op_bne,
    op_illegal
  } uop_t;

  typedef enum logic [1:0] {
    imm_i,
    imm_s,
    imm_b,
    imm_j
  } imm_fmt_t;

  // ----------------------------------------
  // Packets
  // ----------------------------------------

  // From fetch; val travels beside it
  typedef struct packed {
    logic [31:0]        inst;
    logic [31:0]        pc;
    logic [SEQ_MAX-1:0] seq_num;
  } fetch_pkt_t;

  // Shared by both execute pipes
  typedef struct packed {
    logic [31:0]        pc;
    logic [31:0]        op1;
    logic [31:0]        op2;
    uop_t               uop;
    logic [4:0]         waddr;
    logic [SEQ_MAX-1:0] seq_num;
  } issue_pkt_t;

  // Writeback notification from the pipes
  typedef struct packed {
    logic               val;
    logic               wen;
    logic [4:0]         waddr;
    logic [31:0]        wdata;
    logic [SEQ_MAX-1:0] seq_num;
  } complete_t;

endpackage

// File: verilog/inst_decoder.sv
// Combinational TinyRV1 decoder; unknown encodings give op_illegal
// jr is matched as jalr with funct3 000, rd and offset are not checked
// Unused source addresses are forced to x0 so they never stall

`timescale 1ns/1ps

module inst_decoder (
  input  logic [31:0]           inst,
  output tinyrv1_pkg::uop_t     uop,
  output logic [4:0]            raddr0,
  output logic [4:0]            raddr1,
  output logic [4:0]            waddr,
  output logic                  wen,
  output tinyrv1_pkg::imm_fmt_t imm_fmt,
  output logic                  op2_imm
);

  import tinyrv1_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [4:0] rd;
  logic [4:0] rs1;
  logic [4:0] rs2;

  // Standard RISC-V field positions
  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  // ----------------------------------------
  // Encoding match
  // ----------------------------------------

  always_comb begin
    uop = op_illegal;
    case (opcode)
      OPC_OP: begin
        if (funct3 == F3_ADD && funct7 == F7_ADD) begin
          uop = op_add;
        end else if (funct3 == F3_MUL && funct7 == F7_MUL) begin
          uop = op_mul;
        end
      end
      OPC_OP_IMM: if (funct3 == F3_ADDI) uop = op_addi;
      OPC_LOAD:   if (funct3 == F3_LW) uop = op_lw;
      OPC_STORE:  if (funct3 == F3_SW) uop = op_sw;
      OPC_BRANCH: if (funct3 == F3_BNE) uop = op_bne;
      OPC_JALR:   if (funct3 == F3_JR) uop = op_jr;
      OPC_JAL:    uop = op_jal;
      default:    uop = op_illegal;
    endcase
  end

  // ----------------------------------------
  // Operand and writeback controls per uop
  // ----------------------------------------

  always_comb begin
    raddr0  = '0;
    raddr1  = '0;
    wen     = 1'b0;
    op2_imm = 1'b0;
    imm_fmt = imm_i;
    case (uop)
      op_add, op_mul: begin
        raddr0 = rs1;
        raddr1 = rs2;
        wen    = 1'b1;
      end
      op_addi, op_lw: begin
        raddr0  = rs1;
        wen     = 1'b1;
        op2_imm = 1'b1;
      end
      // Store and branch still read rs2 for hazard tracking
      op_sw: begin
        raddr0  = rs1;
        raddr1  = rs2;
        op2_imm = 1'b1;
        imm_fmt = imm_s;
      end
      op_bne: begin
        raddr0  = rs1;
        raddr1  = rs2;
        op2_imm = 1'b1;
        imm_fmt = imm_b;
      end
      op_jal: begin
        wen     = 1'b1;
        op2_imm = 1'b1;
        imm_fmt = imm_j;
      end
      op_jr: begin
        raddr0  = rs1;
        op2_imm = 1'b1;
      end
      default: begin
        wen = 1'b0;
      end
    endcase
  end

  // Non-writers report x0 as destination
  assign waddr = wen ? rd : 5'd0;

endmodule

// File: verilog/imm_gen.sv
// Immediate builder for the I, S, B and J formats
// Always sign-extends from inst[31]; no U format

`timescale 1ns/1ps

module imm_gen (
  input  logic [31:0]           inst,
  input  tinyrv1_pkg::imm_fmt_t imm_fmt,
  output logic [31:0]           imm
);

  import tinyrv1_pkg::*;

  always_comb begin
    case (imm_fmt)
      // Loads, addi, jalr
      imm_i:   imm = {{20{inst[31]}}, inst[31:20]};
      // Stores split the offset around rs2
      imm_s:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      // Branch offset in halfwords with an implicit bit 0
      imm_b:   imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25],
                      inst[11:8], 1'b0};
      // jal offset of 21 bits
      imm_j:   imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20],
                      inst[30:21], 1'b0};
      default: imm = '0;
    endcase
  end

endmodule

// File: verilog/scoreboard_regfile.sv
// 32 x 32-bit register file with a pending bit per register
// Reads are combinational with no bypass of a same-cycle completion
// x0 reads zero and is never pending; set beats clear on the same register

`timescale 1ns/1ps

module scoreboard_regfile (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [4:0]             raddr0,
  input  logic [4:0]             raddr1,
  output logic [31:0]            rdata0,
  output logic [31:0]            rdata1,
  output logic                   pend0,
  output logic                   pend1,
  input  logic [4:0]             set_addr,
  input  logic                   set_en,
  input  tinyrv1_pkg::complete_t complete
);

  logic [31:0] regs [32];
  logic [31:0] pending;
  logic        wr_en;

  // Only real writes to nonzero registers count
  assign wr_en = complete.val & complete.wen & (complete.waddr != 5'd0);

  // ----------------------------------------
  // Read ports
  // ----------------------------------------

  assign rdata0 = (raddr0 == 5'd0) ? 32'd0 : regs[raddr0];
  assign rdata1 = (raddr1 == 5'd0) ? 32'd0 : regs[raddr1];
  assign pend0  = pending[raddr0];
  assign pend1  = pending[raddr1];

  // ----------------------------------------
  // Data write from completion
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (wr_en) begin
      regs[complete.waddr] <= complete.wdata;
    end
  end

  // ----------------------------------------
  // Pending bits
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      if (wr_en) begin
        pending[complete.waddr] <= 1'b0;
      end
      // Later assignment wins, so a new issue keeps its bit
      if (set_en && set_addr != 5'd0) begin
        pending[set_addr] <= 1'b1;
      end
    end
  end

endmodule

// File: verilog/issue_router.sv
// Picks one of the two execute pipes from the uop
// mul, lw and sw go to the mul/memory pipe, the rest to the ALU pipe
// op_illegal drains through the ALU pipe

`timescale 1ns/1ps

module issue_router (
  input  tinyrv1_pkg::uop_t                    uop,
  input  logic                                 val,
  input  logic [tinyrv1_pkg::NUM_PIPES-1:0]    ex_rdy,
  output logic [tinyrv1_pkg::NUM_PIPES-1:0]    ex_val,
  output logic                                 xfer
);

  import tinyrv1_pkg::*;

  logic pipe_sel;

  // Pipe choice
  always_comb begin
    case (uop)
      op_mul, op_lw, op_sw: pipe_sel = 1'(PIPE_MULMEM);
      default:              pipe_sel = 1'(PIPE_ALU);
    endcase
  end

  // One-hot valid toward the chosen pipe only
  always_comb begin
    ex_val           = '0;
    ex_val[pipe_sel] = val;
  end

  // Handshake completes on the selected pipe
  assign xfer = ex_val[pipe_sel] & ex_rdy[pipe_sel];

endmodule

// File: verilog/decode_issue_unit.sv
// TinyRV1 decode and issue stage, one instruction held at a time
// Stalls on pending sources; no operand bypass and no WAW check
// sw and bne carry their immediate in op2; their rs2 value is not forwarded
// p_seq_num_bits must not exceed tinyrv1_pkg::SEQ_MAX

`timescale 1ns/1ps

module decode_issue_unit #(
  parameter int p_seq_num_bits = 8
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 fetch_val,
  input  tinyrv1_pkg::fetch_pkt_t              fetch_pkt,
  output logic                                 fetch_rdy,
  output logic [tinyrv1_pkg::NUM_PIPES-1:0]    ex_val,
  input  logic [tinyrv1_pkg::NUM_PIPES-1:0]    ex_rdy,
  output tinyrv1_pkg::issue_pkt_t              issue_pkt,
  input  tinyrv1_pkg::complete_t               complete
);

  import tinyrv1_pkg::*;

  // ----------------------------------------
  // Stage register
  // ----------------------------------------

  fetch_pkt_t stage_pkt;
  logic       stage_val;
  logic       fetch_xfer;
  logic       issue_xfer;

  assign fetch_xfer = fetch_val & fetch_rdy;

  // Load wins over drain so slots turn over every cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      stage_val <= 1'b0;
    end else if (fetch_xfer) begin
      stage_val <= 1'b1;
    end else if (issue_xfer) begin
      stage_val <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    if (fetch_xfer) begin
      stage_pkt <= fetch_pkt;
    end
  end

  // ----------------------------------------
  // Decode, immediate, register read
  // ----------------------------------------

  uop_t        dec_uop;
  logic [4:0]  dec_raddr0;
  logic [4:0]  dec_raddr1;
  logic [4:0]  dec_waddr;
  logic        dec_wen;
  imm_fmt_t    dec_imm_fmt;
  logic        dec_op2_imm;
  logic [31:0] imm;
  logic [31:0] rdata0;
  logic [31:0] rdata1;
  logic        pend0;
  logic        pend1;
  logic        stall;

  inst_decoder u_decoder (
    .inst    (stage_pkt.inst),
    .uop     (dec_uop),
    .raddr0  (dec_raddr0),
    .raddr1  (dec_raddr1),
    .waddr   (dec_waddr),
    .wen     (dec_wen),
    .imm_fmt (dec_imm_fmt),
    .op2_imm (dec_op2_imm)
  );

  imm_gen u_imm_gen (
    .inst    (stage_pkt.inst),
    .imm_fmt (dec_imm_fmt),
    .imm     (imm)
  );

  // Destination becomes pending on the issue edge
  scoreboard_regfile u_regfile (
    .clk      (clk),
    .rst      (rst),
    .raddr0   (dec_raddr0),
    .raddr1   (dec_raddr1),
    .rdata0   (rdata0),
    .rdata1   (rdata1),
    .pend0    (pend0),
    .pend1    (pend1),
    .set_addr (dec_waddr),
    .set_en   (dec_wen & issue_xfer),
    .complete (complete)
  );

  // RAW hazard on either source
  assign stall = pend0 | pend1;

  // ----------------------------------------
  // Routing and fetch back-pressure
  // ----------------------------------------

  issue_router u_router (
    .uop    (dec_uop),
    .val    (stage_val & ~stall),
    .ex_rdy (ex_rdy),
    .ex_val (ex_val),
    .xfer   (issue_xfer)
  );

  // Empty stage, or the held one leaves now
  assign fetch_rdy = ~stage_val | issue_xfer;

  // ----------------------------------------
  // Issue packet
  // ----------------------------------------

  always_comb begin
    issue_pkt.pc      = stage_pkt.pc;
    issue_pkt.op1     = rdata0;
    issue_pkt.op2     = dec_op2_imm ? imm : rdata1;
    issue_pkt.uop     = dec_uop;
    issue_pkt.waddr   = dec_waddr;
    // Only the low seq bits are carried
    issue_pkt.seq_num = SEQ_MAX'(stage_pkt.seq_num[p_seq_num_bits-1:0]);
  end

endmodule

// File: verification/tb_decode_issue.sv
// Testbench for decode_issue_unit; plays fetch, both execute pipes and completion
// Case file is read relative to the project root; registers preloaded to 0x100 + index
// Inputs change on the falling edge, outputs are sampled 1 ns later

`timescale 1ns/1ps

module tb_decode_issue;

  import tinyrv1_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int STREAM_LEN     = 24;
  localparam int STALL_CYCLES   = 6;

  logic        clk = 1'b0;
  logic        rst;
  logic        fetch_val;
  fetch_pkt_t  fetch_pkt;
  logic        fetch_rdy;
  logic [1:0]  ex_val;
  logic [1:0]  ex_rdy;
  issue_pkt_t  issue_pkt;
  complete_t   complete;

  int          checks;
  int          errors;

  decode_issue_unit #(
    .p_seq_num_bits (8)
  ) dut (
    .clk       (clk),
    .rst       (rst),
    .fetch_val (fetch_val),
    .fetch_pkt (fetch_pkt),
    .fetch_rdy (fetch_rdy),
    .ex_val    (ex_val),
    .ex_rdy    (ex_rdy),
    .issue_pkt (issue_pkt),
    .complete  (complete)
  );

  // 20 ns period
  always #10 clk = ~clk;

  // ----------------------------------------
  // Checking and end of run
  // ----------------------------------------

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    errors++;
    $display("Timeout after %0d cycles waiting for %s", TIMEOUT_CYCLES, what);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    $display("Testbench failed");
    $fatal(1, "run stopped");
  endtask

  task automatic end_run();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  endtask

  // ----------------------------------------
  // Fetch, pipe and completion roles
  // ----------------------------------------

  // Entered at a falling edge, returns at the falling edge after the accept
  task automatic send_inst(input logic [31:0] inst, input logic [31:0] pc,
                           input logic [7:0] seq, output logic [1:0] ex_val_seen);
    int   waited;
    logic accepted;
    waited            = 0;
    accepted          = 1'b0;
    fetch_val         = 1'b1;
    fetch_pkt.inst    = inst;
    fetch_pkt.pc      = pc;
    fetch_pkt.seq_num = seq;
    while (!accepted) begin
      #1;
      accepted    = fetch_rdy;
      ex_val_seen = ex_val;
      @(negedge clk);
      waited++;
      if (!accepted && waited > TIMEOUT_CYCLES) begin
        abort_on_timeout("fetch_rdy");
      end
    end
    fetch_val = 1'b0;
  endtask

  // Pipes assumed ready here, so a seen ex_val transfers at the next edge
  task automatic wait_issue(output logic [1:0] val_seen, output issue_pkt_t pkt_seen);
    int   waited;
    logic seen;
    waited = 0;
    seen   = 1'b0;
    while (!seen) begin
      #1;
      seen     = (ex_val != 2'b00);
      val_seen = ex_val;
      pkt_seen = issue_pkt;
      @(negedge clk);
      waited++;
      if (!seen && waited > TIMEOUT_CYCLES) begin
        abort_on_timeout("an instruction to issue");
      end
    end
  endtask

  // Written at the rising edge inside the call
  task automatic send_completion(input logic [4:0] addr, input logic [31:0] data);
    complete.val     = 1'b1;
    complete.wen     = 1'b1;
    complete.waddr   = addr;
    complete.wdata   = data;
    complete.seq_num = '0;
    @(negedge clk);
    complete = '0;
  endtask

  task automatic preload_registers();
    for (int i = 1; i < 32; i++) begin
      send_completion(5'(i), 32'h100 + 32'(i));
    end
    // Dropped by the DUT so x0 stays zero
    send_completion(5'd0, 32'hdeadbeef);
  endtask

  // ----------------------------------------
  // Case file replay
  // ----------------------------------------

  task automatic replay_cases();
    int               fd;
    int               n;
    int               seq;
    logic [8*256-1:0] text_line;
    logic [31:0]      c_inst;
    logic [31:0]      c_pc;
    logic [31:0]      c_pipe;
    logic [31:0]      c_uop;
    logic [31:0]      c_waddr;
    logic [31:0]      c_op1;
    logic [31:0]      c_op2;
    logic [1:0]       acc_val;
    logic [1:0]       got_val;
    logic [1:0]       exp_val;
    issue_pkt_t       got_pkt;
    seq = 0;
    fd  = $fopen("verification/decode_issue_cases.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open the case file");
      return;
    end
    while ($fgets(text_line, fd) != 0) begin
      // Comment lines give zero fields
      n = $sscanf(text_line, "%h %h %h %h %h %h %h",
                  c_inst, c_pc, c_pipe, c_uop, c_waddr, c_op1, c_op2);
      if (n == 7) begin
        send_inst(c_inst, c_pc, 8'(seq), acc_val);
        // Stage was empty at the first accept
        if (seq == 0) begin
          check_value("ex_val at first accept", 32'(acc_val), 32'd0);
        end
        wait_issue(got_val, got_pkt);
        exp_val = (c_pipe == 32'd0) ? 2'b01 : 2'b10;
        check_value($sformatf("ex_val (pc %08h)", c_pc), 32'(got_val), 32'(exp_val));
        check_value($sformatf("uop (pc %08h)", c_pc), 32'(got_pkt.uop), c_uop);
        check_value($sformatf("waddr (pc %08h)", c_pc), 32'(got_pkt.waddr), c_waddr);
        check_value($sformatf("pc (pc %08h)", c_pc), got_pkt.pc, c_pc);
        check_value($sformatf("op1 (pc %08h)", c_pc), got_pkt.op1, c_op1);
        check_value($sformatf("op2 (pc %08h)", c_pc), got_pkt.op2, c_op2);
        check_value($sformatf("seq_num (pc %08h)", c_pc), 32'(got_pkt.seq_num), 32'(seq));
        // Writeback restores the preload value
        if (c_waddr != 32'd0) begin
          send_completion(c_waddr[4:0], 32'h100 + c_waddr);
        end
        seq++;
      end else if (n > 0) begin
        errors++;
        $display("Malformed line in the case file");
      end
    end
    $fclose(fd);
    if (seq == 0) begin
      errors++;
      $display("No cases found in the case file");
    end
  endtask

  // ----------------------------------------
  // RAW hazard
  // ----------------------------------------

  task automatic check_raw_hazard();
    logic [1:0] acc_val;
    logic [1:0] got_val;
    issue_pkt_t got_pkt;
    // add x5, x1, x2 with its completion held back
    send_inst(32'h002082b3, 32'h00002000, 8'd100, acc_val);
    wait_issue(got_val, got_pkt);
    check_value("waddr of RAW producer", 32'(got_pkt.waddr), 32'd5);
    // add x6, x5, x0 has to wait on x5
    send_inst(32'h00028333, 32'h00002004, 8'd101, acc_val);
    repeat (STALL_CYCLES) begin
      #1;
      check_value("ex_val during RAW stall", 32'(ex_val), 32'd0);
      check_value("fetch_rdy during RAW stall", 32'(fetch_rdy), 32'd0);
      @(negedge clk);
    end
    send_completion(5'd5, 32'h00005a5a);
    wait_issue(got_val, got_pkt);
    check_value("op1 after RAW completion", got_pkt.op1, 32'h00005a5a);
    check_value("seq_num after RAW completion", 32'(got_pkt.seq_num), 32'd101);
    send_completion(5'd6, 32'h00000106);
    send_completion(5'd5, 32'h00000105);
  endtask

  // ----------------------------------------
  // Random back-pressure stream
  // ----------------------------------------

  // Non-writers or x0 writers only, so nothing stalls
  function automatic logic [31:0] stream_inst(input int k);
    case (k % 4)
      0:       return 32'h00508013;  // addi x0, x1, 5
      1:       return 32'h00d72423;  // sw x13, 8(x14)
      2:       return 32'h01289863;  // bne x17, x18, 16
      default: return 32'h02628033;  // mul x0, x5, x6
    endcase
  endfunction

  task automatic feed_stream();
    logic [1:0] acc_val;
    for (int k = 0; k < STREAM_LEN; k++) begin
      send_inst(stream_inst(k), 32'h00003000 + 32'(4 * k), 8'(k), acc_val);
    end
  endtask

  task automatic drain_stream();
    int         issued;
    int         idle;
    logic       held;
    logic [1:0] prev_val;
    logic [1:0] exp_val;
    issue_pkt_t prev_pkt;
    issued   = 0;
    idle     = 0;
    held     = 1'b0;
    prev_val = '0;
    prev_pkt = '0;
    while (issued < STREAM_LEN) begin
      ex_rdy = 2'($urandom());
      #1;
      // Held packet must not move
      if (held) begin
        check_value("ex_val while held", 32'(ex_val), 32'(prev_val));
        checks++;
        assert (issue_pkt == prev_pkt) else begin
          errors++;
          $display("CHECK FAILED issue_pkt while held: got 0x%h, expected 0x%h",
                   issue_pkt, prev_pkt);
        end
      end
      if ((ex_val & ex_rdy) != 2'b00) begin
        // Even seq to ALU, odd to mul/memory
        exp_val = issued[0] ? 2'b10 : 2'b01;
        check_value("ex_val in stream", 32'(ex_val), 32'(exp_val));
        check_value("seq_num in stream", 32'(issue_pkt.seq_num), 32'(issued));
        issued++;
        idle = 0;
        held = 1'b0;
      end else begin
        held = (ex_val != 2'b00);
        idle++;
      end
      prev_val = ex_val;
      prev_pkt = issue_pkt;
      @(negedge clk);
      if (idle > TIMEOUT_CYCLES) begin
        abort_on_timeout("the back-pressure stream to drain");
      end
    end
    // No extra issue after the last one
    #1;
    check_value("ex_val after stream", 32'(ex_val), 32'd0);
  endtask

  task automatic check_backpressure();
    fork
      feed_stream();
      drain_stream();
    join
    ex_rdy = 2'b11;
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------

  initial begin
    void'($urandom(77));
    rst       = 1'b1;
    fetch_val = 1'b0;
    fetch_pkt = '0;
    ex_rdy    = 2'b00;
    complete  = '0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;
    check_value("ex_val after reset", 32'(ex_val), 32'd0);
    check_value("fetch_rdy after reset", 32'(fetch_rdy), 32'd1);
    @(negedge clk);
    ex_rdy = 2'b11;
    preload_registers();
    replay_cases();
    check_raw_hazard();
    check_backpressure();
    end_run();
  end

endmodule

// File: verification/decode_issue_cases.txt
# Columns (hex): inst pc pipe uop waddr op1 op2; pipe 0 = ALU, 1 = mul/memory
# uop codes: add 0, addi 1, mul 2, lw 3, sw 4, jal 5, jr 6, bne 7, illegal 8
002081b3 00001000 0 0 03 00000101 00000102  add x3, x1, x2
02628233 00001004 1 2 04 00000105 00000106  mul x4, x5, x6
ffb40393 00001008 0 1 07 00000108 fffffffb  addi x7, x8, -5
01052483 0000100c 1 3 09 0000010a 00000010  lw x9, 16(x10)
ffc62583 00001010 1 3 0b 0000010c fffffffc  lw x11, -4(x12)
00d72423 00001014 1 4 00 0000010e 00000008  sw x13, 8(x14)
fef82a23 00001018 1 4 00 00000110 fffffff4  sw x15, -12(x16)
01289863 0000101c 0 7 00 00000111 00000010  bne x17, x18, 16
ff499ce3 00001020 0 7 00 00000113 fffffff8  bne x19, x20, -8
001000ef 00001024 0 5 01 00000000 00000800  jal x1, 2048
ff1ff16f 00001028 0 5 02 00000000 fffffff0  jal x2, -16
000a8067 0000102c 0 6 00 00000115 00000000  jr x21
00000b33 00001030 0 0 16 00000000 00000000  add x22, x0, x0
00508013 00001034 0 1 00 00000101 00000005  addi x0, x1, 5
00000bb3 00001038 0 0 17 00000000 00000000  add x23, x0, x0
02300c33 0000103c 1 2 18 00000000 00000103  mul x24, x0, x3
00000000 00001040 0 8 00 00000000 00000000  illegal

// File: compile.f
verilog/tinyrv1_pkg.sv
verilog/inst_decoder.sv
verilog/imm_gen.sv
verilog/scoreboard_regfile.sv
verilog/issue_router.sv
verilog/decode_issue_unit.sv
verification/tb_decode_issue.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs tb_decode_issue with Verilator from the project root

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_decode_issue -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_decode_issue > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "Testbench passed" "$LOG"; then
  exit 0
fi

echo "Pass message not found in $LOG"
exit 1
